/* common/vga_pkg.sv */
// ------------------------------------------------
// Shared types and constants for the VGA planar
// memory path. Import with vga_pkg::* in the module
// header of any block that needs them.
// ------------------------------------------------
package vga_pkg;

  // Live graphics controller settings
  typedef struct packed {
    logic [1:0] write_mode;
    logic [1:0] raster_op;
    logic [7:0] bitmask;
    logic [3:0] set_reset;
    logic [3:0] enable_set_reset;
    logic [3:0] map_mask;
    logic [1:0] read_map_select;
    logic       memory_mapping1;
  } vga_gfx_cfg_t;

  // Plane 0 sits in the low byte
  typedef struct packed {
    logic [7:0] plane3;
    logic [7:0] plane2;
    logic [7:0] plane1;
    logic [7:0] plane0;
  } vga_latch_t;

  // CPU side Wishbone request
  typedef struct packed {
    logic [16:1] adr;
    logic [1:0]  sel;
    logic [15:0] dat;
    logic        we;
    logic        stb;
    logic        cyc;
  } wb_cpu_req_t;

  // SRAM side master request, two extra plane bits
  typedef struct packed {
    logic [17:1] adr;
    logic [1:0]  sel;
    logic [15:0] dat;
    logic        we;
    logic        stb;
    logic        cyc;
  } wb_sram_req_t;

  // Write mode 2 byte: color in the low nibble
  typedef struct packed {
    logic [3:0] pad;
    logic [3:0] color;
  } vga_color_byte_t;

  typedef struct packed {
    vga_color_byte_t hi;
    vga_color_byte_t lo;
  } vga_color_pair_t;

  // One CPU word, pixel data or two colors
  typedef union packed {
    logic [15:0]     raw;
    vga_color_pair_t pair;
  } vga_cpu_word_u;

  // Raster ops
  localparam logic [1:0] ROP_MOVE = 2'd0;
  localparam logic [1:0] ROP_AND  = 2'd1;
  localparam logic [1:0] ROP_OR   = 2'd2;
  localparam logic [1:0] ROP_XOR  = 2'd3;

  // Config port offsets
  localparam logic [3:0] REG_SET_RESET    = 4'd0;
  localparam logic [3:0] REG_EN_SET_RESET = 4'd1;
  localparam logic [3:0] REG_ROP          = 4'd3;
  localparam logic [3:0] REG_READ_MAP     = 4'd4;
  localparam logic [3:0] REG_MODE         = 4'd5;
  localparam logic [3:0] REG_MISC         = 4'd6;
  localparam logic [3:0] REG_BITMASK      = 4'd8;
  localparam logic [3:0] REG_MAP_MASK     = 4'd9;

  localparam logic [7:0] BITMASK_RESET  = 8'hFF;
  localparam logic [3:0] MAP_MASK_RESET = 4'hF;

  // SRAM word offset of a CPU address, plane bits appended later
  function automatic logic [15:1] cpu_offset(input logic [16:1] adr, input logic mm1);
    return mm1 ? {1'b0, adr[14:1]} : adr[15:1];
  endfunction

endpackage

/* verilog/vga_gfx_regs.sv */
// ------------------------------------------------
// Graphics controller registers on a small Wishbone
// classic slave. All fields leave as one config
// struct for the read and write paths.
// ------------------------------------------------
`timescale 1ns/1ps

module vga_gfx_regs
  import vga_pkg::*;
(
  input  logic         wb_clk_i,
  input  logic         arst_n_i,
  input  logic [3:0]   cfg_adr_i,
  input  logic [7:0]   cfg_dat_i,
  input  logic         cfg_we_i,
  input  logic         cfg_stb_i,
  input  logic         cfg_cyc_i,
  output logic [7:0]   cfg_dat_o,
  output logic         cfg_ack_o,
  output vga_gfx_cfg_t cfg_o
);

  vga_gfx_cfg_t cfg_q;
  logic         access;

  // New access only while no ack is pending
  assign access = cfg_stb_i & cfg_cyc_i & ~cfg_ack_o;

  // One cycle ack, cycle after the strobe is seen
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_ack_o <= 1'b0;
    end else begin
      cfg_ack_o <= access;
    end
  end

  // Register writes land on the ack edge
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q          <= '0;
      cfg_q.bitmask  <= BITMASK_RESET;
      cfg_q.map_mask <= MAP_MASK_RESET;
    end else if (access && cfg_we_i) begin
      case (cfg_adr_i)
        REG_SET_RESET:    cfg_q.set_reset        <= cfg_dat_i[3:0];
        REG_EN_SET_RESET: cfg_q.enable_set_reset <= cfg_dat_i[3:0];
        REG_ROP:          cfg_q.raster_op        <= cfg_dat_i[4:3];
        REG_READ_MAP:     cfg_q.read_map_select  <= cfg_dat_i[1:0];
        REG_MODE:         cfg_q.write_mode       <= cfg_dat_i[1:0];
        REG_MISC:         cfg_q.memory_mapping1  <= cfg_dat_i[2];
        REG_BITMASK:      cfg_q.bitmask          <= cfg_dat_i;
        REG_MAP_MASK:     cfg_q.map_mask         <= cfg_dat_i[3:0];
        default: ;
      endcase
    end
  end

  // Readback mux, fields back in their bit positions
  // Address is held through the cycle so data is valid with ack
  always_comb begin
    case (cfg_adr_i)
      REG_SET_RESET:    cfg_dat_o = {4'h0, cfg_q.set_reset};
      REG_EN_SET_RESET: cfg_dat_o = {4'h0, cfg_q.enable_set_reset};
      REG_ROP:          cfg_dat_o = {3'b000, cfg_q.raster_op, 3'b000};
      REG_READ_MAP:     cfg_dat_o = {6'h00, cfg_q.read_map_select};
      REG_MODE:         cfg_dat_o = {6'h00, cfg_q.write_mode};
      REG_MISC:         cfg_dat_o = {5'h00, cfg_q.memory_mapping1, 2'b00};
      REG_BITMASK:      cfg_dat_o = cfg_q.bitmask;
      REG_MAP_MASK:     cfg_dat_o = {4'h0, cfg_q.map_mask};
      // Unmapped offsets read zero
      default:          cfg_dat_o = 8'h00;
    endcase
  end

  assign cfg_o = cfg_q;

endmodule

/* vga_write/vga_write_iface.sv */
// ------------------------------------------------
// CPU write path. Builds the word for each plane from
// CPU data, latches and config, then walks planes 0
// to 3 issuing one SRAM write per enabled plane.
// ------------------------------------------------
`timescale 1ns/1ps

module vga_write_iface
  import vga_pkg::*;
(
  input  logic         wb_clk_i,
  input  logic         arst_n_i,
  input  wb_cpu_req_t  req_i,
  input  vga_gfx_cfg_t cfg_i,
  input  vga_latch_t   latch_i,
  input  logic         sram_ack_i,
  output logic         ack_o,
  output wb_sram_req_t sram_req_o
);

  vga_cpu_word_u     cpu_word;
  logic [3:0][7:0]   latch_arr;
  logic [3:0][15:0]  plane_wd;
  logic [15:0]       mask16;
  logic [1:0]        plane_q;
  logic              active;
  logic              write_en;
  logic              step_done;

  assign cpu_word.raw = req_i.dat;
  // Index latches by plane number
  assign latch_arr    = latch_i;
  assign mask16       = {2{cfg_i.bitmask}};

  // Plane words for all four planes
  always_comb begin
    logic [15:0] lat16;
    logic [15:0] src;
    logic [15:0] rop_res;
    logic [15:0] mode0;
    logic [15:0] mode2;

    for (int p = 0; p < 4; p++) begin
      lat16 = {2{latch_arr[p]}};

      // Set/reset overrides CPU data per plane
      if (cfg_i.enable_set_reset[p]) begin
        src = {16{cfg_i.set_reset[p]}};
      end else begin
        src = cpu_word.raw;
      end

      case (cfg_i.raster_op)
        ROP_AND: rop_res = src & lat16;
        ROP_OR:  rop_res = src | lat16;
        ROP_XOR: rop_res = src ^ lat16;
        default: rop_res = src;
      endcase

      // Bit mask picks result or latch bits
      mode0 = (rop_res & mask16) | (lat16 & ~mask16);

      // Each color nibble bit p expands to the bit mask, no raster op
      mode2[15:8] = cpu_word.pair.hi.color[p] ? cfg_i.bitmask : 8'h00;
      mode2[7:0]  = cpu_word.pair.lo.color[p] ? cfg_i.bitmask : 8'h00;
      mode2       = mode2 | (lat16 & ~mask16);

      case (cfg_i.write_mode)
        2'd1:    plane_wd[p] = lat16;
        2'd2:    plane_wd[p] = mode2;
        // Mode 3 unsupported, behaves as mode 0
        default: plane_wd[p] = mode0;
      endcase
    end
  end

  // Current plane enabled by map mask?
  assign active    = req_i.stb & req_i.cyc;
  assign write_en  = cfg_i.map_mask[plane_q];

  // Masked plane finishes at once, enabled one waits for SRAM
  assign step_done = active & (sram_ack_i | ~write_en);

  // CPU ack in the step closing plane 3
  assign ack_o = step_done & (plane_q == 2'd3);

  // Plane counter, wraps to 0 after plane 3
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      plane_q <= 2'd0;
    end else if (step_done) begin
      plane_q <= plane_q + 2'd1;
    end
  end

  // SRAM write request for the current plane
  always_comb begin
    sram_req_o.adr = {cpu_offset(req_i.adr, cfg_i.memory_mapping1), plane_q};
    sram_req_o.sel = req_i.sel;
    sram_req_o.dat = plane_wd[plane_q];
    sram_req_o.we  = active & write_en;
    sram_req_o.stb = active & write_en;
    sram_req_o.cyc = active & write_en;
  end

endmodule

/* vga_read/vga_read_iface.sv */
// ------------------------------------------------
// CPU read path. Fetches all four planes of a word,
// reloads the latches and returns the byte of the
// plane given by read map select.
// ------------------------------------------------
`timescale 1ns/1ps

module vga_read_iface
  import vga_pkg::*;
(
  input  logic         wb_clk_i,
  input  logic         arst_n_i,
  input  wb_cpu_req_t  req_i,
  input  vga_gfx_cfg_t cfg_i,
  input  logic [15:0]  sram_dat_i,
  input  logic         sram_ack_i,
  output logic         ack_o,
  output logic [15:0]  dat_o,
  output vga_latch_t   latch_o,
  output wb_sram_req_t sram_req_o
);

  logic [3:0][7:0] latch_q;
  logic [1:0]      plane_q;
  logic [7:0]      sel_byte;
  logic            active;
  logic            step_done;

  assign active    = req_i.stb & req_i.cyc;
  assign step_done = active & sram_ack_i;

  // Plane counter and latch capture, one plane per SRAM ack
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      plane_q <= 2'd0;
      latch_q <= '0;
    end else if (step_done) begin
      plane_q          <= plane_q + 2'd1;
      // Latches keep the low byte only
      latch_q[plane_q] <= sram_dat_i[7:0];
    end
  end

  // Done with the plane 3 ack
  assign ack_o = step_done & (plane_q == 2'd3);

  // Plane 3 is still on the bus at the final ack
  always_comb begin
    if (cfg_i.read_map_select == 2'd3) begin
      sel_byte = sram_dat_i[7:0];
    end else begin
      sel_byte = latch_q[cfg_i.read_map_select];
    end
  end

  // Same byte in both halves
  assign dat_o   = {2{sel_byte}};
  assign latch_o = latch_q;

  // Every plane is read, map mask does not apply
  always_comb begin
    sram_req_o.adr = {cpu_offset(req_i.adr, cfg_i.memory_mapping1), plane_q};
    sram_req_o.sel = req_i.sel;
    sram_req_o.dat = 16'h0000;
    sram_req_o.we  = 1'b0;
    sram_req_o.stb = active;
    sram_req_o.cyc = active;
  end

endmodule

/* verilog/vga_mem_router.sv */
// ------------------------------------------------
// Sends each CPU cycle to the read or write path by
// its we bit and merges both SRAM masters into one.
// ------------------------------------------------
`timescale 1ns/1ps

module vga_mem_router
  import vga_pkg::*;
(
  input  wb_cpu_req_t  cpu_req_i,
  input  logic         rd_ack_i,
  input  logic [15:0]  rd_dat_i,
  input  logic         wr_ack_i,
  input  wb_sram_req_t rd_sram_req_i,
  input  wb_sram_req_t wr_sram_req_i,
  output logic [15:0]  cpu_dat_o,
  output logic         cpu_ack_o,
  output wb_cpu_req_t  rd_req_o,
  output wb_cpu_req_t  wr_req_o,
  output wb_sram_req_t sram_req_o
);

  logic is_wr;

  assign is_wr = cpu_req_i.we;

  // Idle side sees no strobe and no cycle
  always_comb begin
    rd_req_o     = cpu_req_i;
    rd_req_o.stb = cpu_req_i.stb & ~is_wr;
    rd_req_o.cyc = cpu_req_i.cyc & ~is_wr;

    wr_req_o     = cpu_req_i;
    wr_req_o.stb = cpu_req_i.stb & is_wr;
    wr_req_o.cyc = cpu_req_i.cyc & is_wr;
  end

  // Only one side runs, so a plain select is enough
  assign sram_req_o = is_wr ? wr_sram_req_i : rd_sram_req_i;

  // Acks never overlap
  assign cpu_ack_o  = rd_ack_i | wr_ack_i;

  // Writes return zero data
  assign cpu_dat_o  = is_wr ? 16'h0000 : rd_dat_i;

endmodule

/* verilog/vga_mem_top.sv */
// ------------------------------------------------
// Top of the VGA planar memory path. Joins the config
// registers, read and write paths and the router to
// the CPU, config and SRAM ports.
// ------------------------------------------------
`timescale 1ns/1ps

module vga_mem_top
  import vga_pkg::*;
(
  input  logic         wb_clk_i,
  input  logic         arst_n_i,

  // CPU port
  input  wb_cpu_req_t  cpu_req_i,
  output logic [15:0]  cpu_dat_o,
  output logic         cpu_ack_o,

  // Config port
  input  logic [3:0]   cfg_adr_i,
  input  logic [7:0]   cfg_dat_i,
  input  logic         cfg_we_i,
  input  logic         cfg_stb_i,
  input  logic         cfg_cyc_i,
  output logic [7:0]   cfg_dat_o,
  output logic         cfg_ack_o,

  // SRAM master port
  output wb_sram_req_t sram_req_o,
  input  logic [15:0]  sram_dat_i,
  input  logic         sram_ack_i
);

  vga_gfx_cfg_t cfg;
  vga_latch_t   latch;
  wb_cpu_req_t  rd_req;
  wb_cpu_req_t  wr_req;
  wb_sram_req_t rd_sram_req;
  wb_sram_req_t wr_sram_req;
  logic         rd_ack;
  logic         wr_ack;
  logic [15:0]  rd_dat;

  vga_gfx_regs i_regs (
    .wb_clk_i  (wb_clk_i),
    .arst_n_i  (arst_n_i),
    .cfg_adr_i (cfg_adr_i),
    .cfg_dat_i (cfg_dat_i),
    .cfg_we_i  (cfg_we_i),
    .cfg_stb_i (cfg_stb_i),
    .cfg_cyc_i (cfg_cyc_i),
    .cfg_dat_o (cfg_dat_o),
    .cfg_ack_o (cfg_ack_o),
    .cfg_o     (cfg)
  );

  // Both paths share the SRAM ack, only the active one uses it
  vga_write_iface i_write (
    .wb_clk_i   (wb_clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (wr_req),
    .cfg_i      (cfg),
    .latch_i    (latch),
    .sram_ack_i (sram_ack_i),
    .ack_o      (wr_ack),
    .sram_req_o (wr_sram_req)
  );

  vga_read_iface i_read (
    .wb_clk_i   (wb_clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (rd_req),
    .cfg_i      (cfg),
    .sram_dat_i (sram_dat_i),
    .sram_ack_i (sram_ack_i),
    .ack_o      (rd_ack),
    .dat_o      (rd_dat),
    .latch_o    (latch),
    .sram_req_o (rd_sram_req)
  );

  vga_mem_router i_router (
    .cpu_req_i     (cpu_req_i),
    .rd_ack_i      (rd_ack),
    .rd_dat_i      (rd_dat),
    .wr_ack_i      (wr_ack),
    .rd_sram_req_i (rd_sram_req),
    .wr_sram_req_i (wr_sram_req),
    .cpu_dat_o     (cpu_dat_o),
    .cpu_ack_o     (cpu_ack_o),
    .rd_req_o      (rd_req),
    .wr_req_o      (wr_req),
    .sram_req_o    (sram_req_o)
  );

endmodule

/* verif/vga_mem_tb.sv */
// ------------------------------------------------
// Testbench for the VGA planar memory path. Plays
// the vector file against the DUT, models the SRAM
// and checks results against a reference model.
// ------------------------------------------------
`timescale 1ns/1ps

module vga_mem_tb
  import vga_pkg::*;
;

  logic         wb_clk_i;
  logic         arst_n_i;
  wb_cpu_req_t  cpu_req;
  logic [15:0]  cpu_dat;
  logic         cpu_ack;
  logic [3:0]   cfg_adr;
  logic [7:0]   cfg_wdat;
  logic         cfg_we;
  logic         cfg_stb;
  logic         cfg_cyc;
  logic [7:0]   cfg_rdat;
  logic         cfg_ack;
  wb_sram_req_t sram_req;
  logic [15:0]  sram_dat = 16'h0000;
  logic         sram_ack = 1'b0;

  logic [15:0]  mem [0:131071];
  vga_gfx_cfg_t cfg_m;
  logic [7:0]   lat_m [4];
  integer       seed = 463;
  integer       wait_cnt;
  integer       n_lines = 0;

  vga_mem_top i_dut (
    .wb_clk_i   (wb_clk_i),
    .arst_n_i   (arst_n_i),
    .cpu_req_i  (cpu_req),
    .cpu_dat_o  (cpu_dat),
    .cpu_ack_o  (cpu_ack),
    .cfg_adr_i  (cfg_adr),
    .cfg_dat_i  (cfg_wdat),
    .cfg_we_i   (cfg_we),
    .cfg_stb_i  (cfg_stb),
    .cfg_cyc_i  (cfg_cyc),
    .cfg_dat_o  (cfg_rdat),
    .cfg_ack_o  (cfg_ack),
    .sram_req_o (sram_req),
    .sram_dat_i (sram_dat),
    .sram_ack_i (sram_ack)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  // SRAM model, 0 to 2 random wait states per access
  always @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sram_ack <= 1'b0;
      sram_dat <= 16'h0000;
      wait_cnt <= 0;
    end else if (sram_ack) begin
      sram_ack <= 1'b0;
    end else if (sram_req.stb && sram_req.cyc) begin
      if (wait_cnt == 0) begin
        sram_ack <= 1'b1;
        wait_cnt <= {$random(seed)} % 3;
        if (sram_req.we) begin
          if (sram_req.sel[0]) mem[sram_req.adr][7:0] = sram_req.dat[7:0];
          if (sram_req.sel[1]) mem[sram_req.adr][15:8] = sram_req.dat[15:8];
        end else begin
          sram_dat <= mem[sram_req.adr];
        end
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  // Run limit scales with the vector count
  initial begin
    wait (n_lines > 0);
    #(n_lines * 500);
    $display("Timeout: the DUT stopped answering before all vectors ran");
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (exp !== act) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_latch(input string name, input vga_latch_t exp, input vga_latch_t act);
    if (exp !== act) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "latch mismatch");
    end
  endtask

  task automatic check_cfg(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "config mismatch");
    end
  endtask

  task automatic cfg_access(input logic [3:0] a, input logic [7:0] d, input logic we,
                            output logic [7:0] rd);
    @(posedge wb_clk_i);
    cfg_adr  <= a;
    cfg_wdat <= d;
    cfg_we   <= we;
    cfg_stb  <= 1'b1;
    cfg_cyc  <= 1'b1;
    do @(negedge wb_clk_i); while (!cfg_ack);
    rd = cfg_rdat;
    @(posedge wb_clk_i);
    cfg_stb <= 1'b0;
    cfg_cyc <= 1'b0;
    cfg_we  <= 1'b0;
  endtask

  task automatic cpu_access(input logic [15:0] a, input logic [15:0] d, input logic [1:0] sel,
                            input logic we, output logic [15:0] rd);
    @(posedge wb_clk_i);
    cpu_req.adr <= a;
    cpu_req.dat <= d;
    cpu_req.sel <= sel;
    cpu_req.we  <= we;
    cpu_req.stb <= 1'b1;
    cpu_req.cyc <= 1'b1;
    do @(negedge wb_clk_i); while (!cpu_ack);
    rd = cpu_dat;
    @(posedge wb_clk_i);
    cpu_req.stb <= 1'b0;
    cpu_req.cyc <= 1'b0;
    cpu_req.we  <= 1'b0;
    // Exactly one ack per CPU cycle
    @(negedge wb_clk_i);
    if (cpu_ack) fail_now("CPU ack stayed high after the cycle ended");
  endtask

  // Register model, returns the expected readback
  function automatic logic [7:0] cfg_model_write(input logic [3:0] a, input logic [7:0] d);
    case (a)
      4'd0: cfg_m.set_reset = d[3:0];
      4'd1: cfg_m.enable_set_reset = d[3:0];
      4'd3: cfg_m.raster_op = d[4:3];
      4'd4: cfg_m.read_map_select = d[1:0];
      4'd5: cfg_m.write_mode = d[1:0];
      4'd6: cfg_m.memory_mapping1 = d[2];
      4'd8: cfg_m.bitmask = d;
      4'd9: cfg_m.map_mask = d[3:0];
      default: ;
    endcase
    case (a)
      4'd0, 4'd1, 4'd9: return d & 8'h0F;
      4'd3: return d & 8'h18;
      4'd4, 4'd5: return d & 8'h03;
      4'd6: return d & 8'h04;
      4'd8: return d;
      default: return 8'h00;
    endcase
  endfunction

  // Plane word by the graphics controller write rules
  function automatic logic [15:0] plane_ref(input vga_gfx_cfg_t c, input logic [7:0] lat,
                                           input logic [15:0] d, input int p);
    logic [15:0] l;
    logic [15:0] m;
    logic [15:0] s;
    logic [15:0] r;
    l = {lat, lat};
    m = {c.bitmask, c.bitmask};
    if (c.write_mode == 2'd1) return l;
    if (c.write_mode == 2'd2) begin
      r = {d[8+p] ? c.bitmask : 8'h00, d[p] ? c.bitmask : 8'h00};
      return r | (l & ~m);
    end
    s = c.enable_set_reset[p] ? {16{c.set_reset[p]}} : d;
    case (c.raster_op)
      2'd1: r = s & l;
      2'd2: r = s | l;
      2'd3: r = s ^ l;
      default: r = s;
    endcase
    return (r & m) | (l & ~m);
  endfunction

  // SRAM word index of plane p
  function automatic logic [16:0] sram_index(input logic [15:0] a, input logic mm1,
                                             input int p);
    logic [14:0] off;
    off = mm1 ? {1'b0, a[13:0]} : a[14:0];
    return {off, p[1:0]};
  endfunction

  initial begin
    integer      fd;
    integer      code;
    integer      vec_no;
    string       op;
    string       line;
    string       name;
    logic [16:0] a;
    logic [15:0] d;
    logic [15:0] rd;
    logic [15:0] exp;
    logic [15:0] wd;
    logic [15:0] old [4];
    logic [7:0]  rb;
    logic [1:0]  sel;

    arst_n_i = 1'b0;
    cpu_req  = '0;
    cfg_adr  = 4'h0;
    cfg_wdat = 8'h00;
    cfg_we   = 1'b0;
    cfg_stb  = 1'b0;
    cfg_cyc  = 1'b0;
    vec_no   = 0;
    cfg_m    = '0;
    cfg_m.bitmask  = 8'hFF;
    cfg_m.map_mask = 4'hF;
    for (int p = 0; p < 4; p++) lat_m[p] = 8'h00;
    // Fill pattern depends on every address bit
    for (int i = 0; i < 131072; i++) mem[i] = 16'(i * 40503) ^ 16'(i >> 1);

    fd = $fopen("verif/vga_mem_vectors.txt", "r");
    if (fd == 0) fail_now("Could not open the vector file");
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      n_lines++;
    end
    $fclose(fd);
    fd = $fopen("verif/vga_mem_vectors.txt", "r");

    repeat (3) @(posedge wb_clk_i);
    arst_n_i <= 1'b1;

    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        code = $fgets(line, fd);
        continue;
      end
      vec_no++;
      name = $sformatf("vector %0d (%s)", vec_no, op);
      if (op == "R") begin
        code = $fscanf(fd, "%h %h", a, exp);
        if (code != 2) fail_now($sformatf("Missing fields in vector %0d", vec_no));
        cfg_access(a[3:0], 8'h00, 1'b0, rb);
        check_cfg(name, exp[7:0], rb);
      end else if (op == "C") begin
        code = $fscanf(fd, "%h %h", a, d);
        if (code != 2) fail_now($sformatf("Missing fields in vector %0d", vec_no));
        cfg_access(a[3:0], d[7:0], 1'b1, rb);
        exp[7:0] = cfg_model_write(a[3:0], d[7:0]);
        cfg_access(a[3:0], 8'h00, 1'b0, rb);
        check_cfg(name, exp[7:0], rb);
      end else if (op == "W") begin
        code = $fscanf(fd, "%h %h %h", a, d, sel);
        if (code != 3) fail_now($sformatf("Missing fields in vector %0d", vec_no));
        for (int p = 0; p < 4; p++) old[p] = mem[sram_index(a[15:0], cfg_m.memory_mapping1, p)];
        cpu_access(a[15:0], d, sel, 1'b1, rd);
        for (int p = 0; p < 4; p++) begin
          exp = old[p];
          // Masked planes keep their old word
          if (cfg_m.map_mask[p]) begin
            wd = plane_ref(cfg_m, lat_m[p], d, p);
            if (sel[0]) exp[7:0] = wd[7:0];
            if (sel[1]) exp[15:8] = wd[15:8];
          end
          check_word(name, exp, mem[sram_index(a[15:0], cfg_m.memory_mapping1, p)]);
        end
      end else if (op == "D") begin
        code = $fscanf(fd, "%h %h", a, exp);
        if (code != 2) fail_now($sformatf("Missing fields in vector %0d", vec_no));
        cpu_access(a[15:0], 16'h0000, 2'b11, 1'b0, rd);
        for (int p = 0; p < 4; p++)
          lat_m[p] = mem[sram_index(a[15:0], cfg_m.memory_mapping1, p)][7:0];
        check_word(name, exp, rd);
        check_latch(name, {lat_m[3], lat_m[2], lat_m[1], lat_m[0]}, i_dut.latch);
      end else if (op == "P") begin
        code = $fscanf(fd, "%h %h", a, exp);
        if (code != 2) fail_now($sformatf("Missing fields in vector %0d", vec_no));
        check_word(name, exp, mem[a]);
      end else begin
        fail_now($sformatf("Unknown operation in vector %0d", vec_no));
      end
    end
    $fclose(fd);

    // Plane 3 byte comes straight off the SRAM bus at the last ack
    cfg_access(4'd4, 8'h03, 1'b1, rb);
    void'(cfg_model_write(4'd4, 8'h03));
    cpu_access(16'h0030, 16'h0000, 2'b11, 1'b0, rd);
    for (int p = 0; p < 4; p++) begin
      lat_m[p] = mem[sram_index(16'h0030, cfg_m.memory_mapping1, p)][7:0];
    end
    check_word("read map select 3", {2{lat_m[3]}}, rd);
    check_latch("read map select 3", {lat_m[3], lat_m[2], lat_m[1], lat_m[0]}, i_dut.latch);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* verif/vga_mem_vectors.txt */
# R adr exp: config read | C adr dat: config write with readback | D adr exp: CPU read
# W adr dat sel: CPU write, planes checked by model | P sram_adr exp: plane word check
R 0 00
R 1 00
R 3 00
R 4 00
R 5 00
R 6 00
R 8 FF
R 9 0F
C 0 F5
C 1 F3
C 3 FF
C 4 FE
C 5 FE
C 6 FF
C 8 A5
C 9 FC
C 0 00
C 1 00
C 3 00
C 4 00
C 5 00
C 6 00
C 8 FF
C 9 0F
W 0010 1234 3
P 00040 1234
P 00043 1234
D 0010 3434
C 8 0F
C 3 08
W 0010 F0F0 3
D 0010 3030
C 3 10
W 0010 0F0F 3
D 0010 3F3F
C 3 18
W 0010 FFFF 3
D 0010 3030
C 3 00
W 0010 AAAA 3
D 0010 3A3A
C 8 FF
C 1 05
C 0 04
W 0010 1111 3
P 00040 0000
P 00041 1111
P 00042 FFFF
C 4 02
D 0010 FFFF
C 5 01
W 0020 0000 3
P 00083 1111
C 5 02
C 8 3C
W 0020 0A05 3
P 00080 003C
P 00081 3D01
C 5 00
C 1 00
C 8 FF
C 9 05
W 0030 BEEF 3
C 9 0F
W 0040 1122 3
C 4 01
D 0040 2222
C 6 04
D 4040 2222

/* verilog.f */
common/vga_pkg.sv
verilog/vga_gfx_regs.sv
vga_write/vga_write_iface.sv
vga_read/vga_read_iface.sv
verilog/vga_mem_router.sv
verilog/vga_mem_top.sv
verif/vga_mem_tb.sv

/* Makefile */
# Verilator simulation of the VGA planar memory path

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f verilog.f --top-module vga_mem_tb -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/Vvga_mem_tb); echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
